//--- verilog/pkt_settings.svh
// lane count must stay within 1 to 4 since the destination table holds four entries
`ifndef PKT_SETTINGS_SVH
`define PKT_SETTINGS_SVH

// words per beat, earliest word in the highest lane
`define PKT_LANES 2

// word width is tied to the 48 bit address plus 16 bit serial header
`define PKT_WORD_W 64

// 0 gives random middle words, 1 gives a per-lane counter
`define PKT_CNTR_PAYLOAD 0

// destination per start lane, lane 0 is the rightmost entry
`define PKT_DEST_TABLE {48'h0007ed_ff1234, 48'h123456_ff1234, \
	48'h0007ed_ff0000, 48'h00215a_bdde43}

`endif

//--- verilog/pkt_pkg.sv
// types follow the lane count in pkt_settings.svh and the header layout assumes 64 bit words
package pkt_pkg;

`include "pkt_settings.svh"

	// one flag per lane
	typedef logic [`PKT_LANES-1:0] lane_mask_t;

	// one-hot end byte per lane, zero when the lane holds no end
	typedef logic [8*`PKT_LANES-1:0] eop_pos_t;

	typedef logic [`PKT_WORD_W-1:0] word_t;
	typedef word_t [`PKT_LANES-1:0] beat_data_t;

	typedef logic [47:0] dest_addr_t;
	typedef logic [15:0] serial_t;

	// checker statistics, all wrap at 16 bits
	typedef struct packed {
		logic [15:0] packets;
		logic [15:0] framing_err;
		logic [15:0] dest_err;
		logic [15:0] serial_err;
		logic [15:0] trailer_err;
	} check_counts_t;

	// fixed end word of every packet
	localparam word_t PKT_TRAILER = "caboose.";

	localparam logic [4*48-1:0] PKT_DEST_TBL = `PKT_DEST_TABLE;

	// address a packet carries when it starts in this lane
	function automatic dest_addr_t dest_for_lane(input int lane);
		return PKT_DEST_TBL[lane*48 +: 48];
	endfunction

endpackage

//--- verilog/pkt_stream_if.sv
// a beat moves when valid and ready are both high and the source holds every field until then
`timescale 1ns/1ps

interface pkt_stream_if import pkt_pkg::*; ();

	// framing marks, scanned from the high lane down
	lane_mask_t sop;
	eop_pos_t   eop;

	// payload words, lane order matches the marks
	beat_data_t data;

	// handshake
	logic       valid;
	logic       ready;

	// generator side
	modport src (
		output sop,
		output eop,
		output data,
		output valid,
		input  ready
	);

	// checker side
	modport snk (
		input  sop,
		input  eop,
		input  data,
		input  valid,
		output ready
	);

endinterface

//--- verilog/prbs_source.sv
// random bits are only loosely mixed and are meant for traffic shaping, not for statistics
`timescale 1ns/1ps

module prbs_source import pkt_pkg::*; (
	input  logic        clk,
	input  logic        reset,
	input  logic        advance,
	output word_t       rand_word,
	output logic [15:0] rand_frame,
	output logic        mostly_one
);

	// two galois polynomials so the sequences never line up
	localparam logic [31:0] POLY_A = 32'h8000_0241;
	localparam logic [31:0] POLY_B = 32'h8dea_dfb3;

	logic [31:0] run_cnt;
	logic [31:0] lfsr_a;
	logic [31:0] lfsr_b;

	always_ff @(posedge clk) begin
		if (reset) begin
			run_cnt    <= '0;
			lfsr_a     <= '1;
			lfsr_b     <= '1;
			rand_frame <= '0;
			mostly_one <= 1'b0;
			rand_word  <= '0;
		end else begin
			// run counter only steps while the pipeline moves
			if (advance)
				run_cnt <= run_cnt + 32'd1;
			// feedback taps perturbed by counter bits
			lfsr_a <= {lfsr_a[30:0], 1'b0} ^ ((lfsr_a[31] ^ run_cnt[9]) ? POLY_A : '0);
			lfsr_b <= {lfsr_b[30:0], 1'b0} ^ ((lfsr_b[31] ^ run_cnt[8]) ? POLY_B : '0);
			rand_frame <= run_cnt[23:8] ^ lfsr_a[15:0] ^ lfsr_b[15:0];
			// low only when all three pairs cancel, so about one cycle in four
			mostly_one <= |(lfsr_a[17:16] ^ lfsr_b[17:16] ^ run_cnt[25:24]);
			// junk payload, old bits shift out after a few cycles
			rand_word <= (rand_word << 15) ^ word_t'(rand_frame);
		end
	end

endmodule

//--- verilog/packet_gen.sv
// idle stops new starts but lets an open packet end, and the pipeline only moves while run is high
`timescale 1ns/1ps
`include "pkt_settings.svh"

module packet_gen import pkt_pkg::*; (
	input  logic      clk,
	input  logic      reset,
	input  logic      run,
	input  logic      idle,
	pkt_stream_if.src out,
	output logic      open_pkt
);

	localparam int LANES = `PKT_LANES;

	logic        load;
	logic        adv;
	word_t       rand_word;
	logic [15:0] rand_frame;
	logic        mostly_one;

	lane_mask_t  sop_prelim;
	eop_pos_t    eop_sugg;
	lane_mask_t  nix_sugg;
	lane_mask_t  sop1;
	eop_pos_t    eop1;
	lane_mask_t  nix1;

	lane_mask_t  blank2;
	eop_pos_t    eop_thin;
	lane_mask_t  any_thin;
	lane_mask_t  sop2;
	eop_pos_t    eop2;
	lane_mask_t  any2;

	logic        open_q;
	logic        open_c;
	lane_mask_t  sop_keep;
	eop_pos_t    eop_keep;
	lane_mask_t  sop3;
	eop_pos_t    eop3;

	beat_data_t  data_nxt;
	lane_mask_t  out_end;

	// output register takes a beat when empty or draining, stages stall otherwise
	assign load = ~out.valid | out.ready;
	assign adv  = run & load;

	prbs_source u_prbs (
		.clk        (clk),
		.reset      (reset),
		.advance    (adv),
		.rand_word  (rand_word),
		.rand_frame (rand_frame),
		.mostly_one (mostly_one)
	);

	////////////////////////////////////////////////////////////////////////////
	// stage 1, raw suggestions

	assign sop_prelim = rand_frame[LANES-1:0] & rand_frame[15 -: LANES];

	for (genvar i = 0; i < LANES; i++) begin : g_sugg
		// one candidate end byte per lane, every beat
		assign eop_sugg[8*i +: 8] = 8'b1 << rand_frame[4 + 2*i +: 3];
		assign nix_sugg[i]        = rand_frame[8 + i] ^ rand_frame[15 - i];
		// stage 2 blanking, relaxed while idle so open packets close quickly
		assign blank2[i]            = sop1[i] | (~idle & (mostly_one | nix1[i]));
		assign eop_thin[8*i +: 8]   = eop1[8*i +: 8] & ~{8{blank2[i]}};
		assign any_thin[i]          = |eop_thin[8*i +: 8];
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			sop1 <= '0;
			eop1 <= '0;
			nix1 <= '0;
		end else if (adv) begin
			// more than one start per beat is rejected outright
			sop1 <= (idle || !$onehot0(sop_prelim)) ? '0 : sop_prelim;
			eop1 <= eop_sugg;
			nix1 <= nix_sugg;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// stage 2, thinning

	always_ff @(posedge clk) begin
		if (reset) begin
			sop2 <= '0;
			eop2 <= '0;
			any2 <= '0;
		end else if (adv) begin
			// no start in the beat right after a start
			sop2 <= (|sop2) ? '0 : sop1;
			eop2 <= eop_thin;
			any2 <= any_thin;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// stage 3, alternation fixup, open state carried across beats

	always_comb begin
		open_c   = open_q;
		sop_keep = '0;
		eop_keep = '0;
		for (int i = LANES - 1; i >= 0; i--) begin
			if (open_c) begin
				// inside a packet only an end is kept
				eop_keep[8*i +: 8] = eop2[8*i +: 8];
				open_c = ~any2[i];
			end else begin
				sop_keep[i] = sop2[i];
				open_c = sop2[i];
			end
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			sop3   <= '0;
			eop3   <= '0;
			open_q <= 1'b0;
		end else if (adv) begin
			sop3   <= sop_keep;
			eop3   <= eop_keep;
			open_q <= open_c;
		end
	end

	assign open_pkt = open_q;

	////////////////////////////////////////////////////////////////////////////
	// stage 4, payload and output register

	for (genvar i = 0; i < LANES; i++) begin : g_lane
		serial_t serial_q;
		word_t   cntr_q;

		always_ff @(posedge clk) begin
			if (reset) begin
				serial_q <= '0;
				cntr_q   <= '0;
			end else if (adv) begin
				if (sop3[i])
					serial_q <= serial_q + 16'd1;
				else if (eop3[8*i +: 8] == 8'd0)
					cntr_q <= cntr_q + word_t'(1);
			end
		end

		// header, trailer, or filler
		assign data_nxt[i] = sop3[i] ? {dest_for_lane(i), serial_q} :
			(|eop3[8*i +: 8]) ? PKT_TRAILER :
			(`PKT_CNTR_PAYLOAD != 0) ? cntr_q : rand_word;

		assign out_end[i] = |out.eop[8*i +: 8];
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			out.valid <= 1'b0;
			out.sop   <= '0;
			out.eop   <= '0;
		end else begin
			if (load)
				out.valid <= adv;
			if (adv) begin
				out.sop <= sop3;
				out.eop <= eop3;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (adv)
			out.data <= data_nxt;
	end

	// start and end never share a lane, else the packet would be one word
	a_no_sop_eop_lane: assert property (@(posedge clk) disable iff (reset)
		out.valid |-> (out.sop & out_end) == '0)
		else $error("packet_gen: sop and eop in the same lane");

	// a stalled beat keeps every field
	a_hold_stable: assert property (@(posedge clk) disable iff (reset)
		out.valid && !out.ready |=> out.valid && $stable(out.sop) &&
			$stable(out.eop) && $stable(out.data))
		else $error("packet_gen: beat changed while stalled");

endmodule

//--- verilog/packet_check.sv
// counters wrap at 16 bits and a serial error resynchronizes that lane to the received value
`timescale 1ns/1ps
`include "pkt_settings.svh"

module packet_check import pkt_pkg::*; (
	input  logic          clk,
	input  logic          reset,
	input  logic          hold,
	pkt_stream_if.snk     in,
	output check_counts_t counts,
	output logic          open_pkt
);

	localparam int LANES = `PKT_LANES;

	logic                   accept;
	logic                   open_q;
	logic                   open_c;
	serial_t [LANES-1:0]    exp_q;
	serial_t [LANES-1:0]    exp_c;
	check_counts_t          inc;

	// back-pressure straight from the hold pin
	assign in.ready = ~hold;
	assign accept   = in.valid & in.ready;

	////////////////////////////////////////////////////////////////////////////
	// per-beat scan, high lane first

	always_comb begin
		open_c = open_q;
		exp_c  = exp_q;
		inc    = '0;
		if (accept) begin
			for (int i = LANES - 1; i >= 0; i--) begin
				if (in.sop[i]) begin
					if (open_c)
						inc.framing_err = inc.framing_err + 16'd1;
					// header is address then serial
					if (in.data[i][63:16] != dest_for_lane(i))
						inc.dest_err = inc.dest_err + 16'd1;
					if (in.data[i][15:0] != exp_c[i])
						inc.serial_err = inc.serial_err + 16'd1;
					exp_c[i] = in.data[i][15:0] + 16'd1;
					open_c = 1'b1;
				end
				if (|in.eop[8*i +: 8]) begin
					// end without a start is a framing error, not a packet
					if (!open_c)
						inc.framing_err = inc.framing_err + 16'd1;
					else
						inc.packets = inc.packets + 16'd1;
					if (in.data[i] != PKT_TRAILER)
						inc.trailer_err = inc.trailer_err + 16'd1;
					open_c = 1'b0;
				end
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// state and counters

	always_ff @(posedge clk) begin
		if (reset) begin
			open_q <= 1'b0;
			exp_q  <= '0;
			counts <= '0;
		end else begin
			open_q             <= open_c;
			exp_q              <= exp_c;
			counts.packets     <= counts.packets + inc.packets;
			counts.framing_err <= counts.framing_err + inc.framing_err;
			counts.dest_err    <= counts.dest_err + inc.dest_err;
			counts.serial_err  <= counts.serial_err + inc.serial_err;
			counts.trailer_err <= counts.trailer_err + inc.trailer_err;
		end
	end

	assign open_pkt = open_q;

	// statistics only grow over a run
	a_counts_monotonic: assert property (@(posedge clk) disable iff (reset)
		counts.packets >= $past(counts.packets) &&
		counts.framing_err >= $past(counts.framing_err) &&
		counts.dest_err >= $past(counts.dest_err) &&
		counts.serial_err >= $past(counts.serial_err) &&
		counts.trailer_err >= $past(counts.trailer_err))
		else $error("packet_check: a counter went backwards");

endmodule

//--- verilog/pkt_loop_top.sv
// generator open state stays internal, open_pkt here is what the checker has seen
`timescale 1ns/1ps

module pkt_loop_top import pkt_pkg::*; (
	input  logic          clk,
	input  logic          reset,
	input  logic          run,
	input  logic          idle,
	input  logic          hold,
	output logic          out_valid,
	output logic          out_ready,
	output lane_mask_t    out_sop,
	output eop_pos_t      out_eop,
	output beat_data_t    out_data,
	output check_counts_t counts,
	output logic          open_pkt
);

	pkt_stream_if link ();

	packet_gen u_gen (
		.clk      (clk),
		.reset    (reset),
		.run      (run),
		.idle     (idle),
		.out      (link.src),
		.open_pkt ()
	);

	packet_check u_chk (
		.clk      (clk),
		.reset    (reset),
		.hold     (hold),
		.in       (link.snk),
		.counts   (counts),
		.open_pkt (open_pkt)
	);

	// stream observation
	assign out_valid = link.valid;
	assign out_ready = link.ready;
	assign out_sop   = link.sop;
	assign out_eop   = link.eop;
	assign out_data  = link.data;

endmodule

//--- bench/tb_pkt_loop.sv
// one fixed seed drives all four phases and the idle drain assumes hold stays low until it ends
`timescale 1ns/1ps
`include "pkt_settings.svh"

module tb_pkt_loop import pkt_pkg::*; ();

	localparam int LANES = `PKT_LANES;
	localparam logic [63:0] TRAILER = "caboose.";

	logic          clk;
	logic          reset;
	logic          run;
	logic          idle;
	logic          hold;
	logic          out_valid;
	logic          out_ready;
	lane_mask_t    out_sop;
	eop_pos_t      out_eop;
	beat_data_t    out_data;
	check_counts_t counts;
	logic          open_pkt;
	lane_mask_t    eop_lanes;

	// reference state built only from the framing and header rules
	logic          m_open;
	logic [15:0]   m_serial [LANES];
	int            m_packets;
	int            stalls;
	int            errors;
	bit            quiet;
	bit            ok;

	pkt_loop_top dut (
		.clk       (clk),
		.reset     (reset),
		.run       (run),
		.idle      (idle),
		.hold      (hold),
		.out_valid (out_valid),
		.out_ready (out_ready),
		.out_sop   (out_sop),
		.out_eop   (out_eop),
		.out_data  (out_data),
		.counts    (counts),
		.open_pkt  (open_pkt)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	for (genvar i = 0; i < LANES; i++) begin : g_eop
		assign eop_lanes[i] = |out_eop[8*i +: 8];
	end

	// table entry for a start lane with lane 0 at the right
	function automatic logic [47:0] table_addr(input int lane);
		logic [4*48-1:0] tbl;
		tbl = `PKT_DEST_TABLE;
		return tbl[lane*48 +: 48];
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// reference model with one scan per accepted beat

	always @(posedge clk) begin
		if (reset) begin
			m_open = 1'b0;
			m_packets = 0;
			stalls = 0;
			for (int i = 0; i < LANES; i++)
				m_serial[i] = '0;
		end else if (out_valid && !out_ready) begin
			stalls++;
		end else if (out_valid && out_ready) begin
			// earliest word sits in the top lane
			for (int i = LANES - 1; i >= 0; i--) begin
				if (out_sop[i]) begin
					assert (!m_open) else begin
						$display("Mismatch out_sop lane %0d: start while open, sop %h",
							i, out_sop);
						errors++;
					end
					assert (out_data[i][63:16] == table_addr(i)) else begin
						$display("Mismatch out_data[%0d] address: got %h expected %h",
							i, out_data[i][63:16], table_addr(i));
						errors++;
					end
					assert (out_data[i][15:0] == m_serial[i]) else begin
						$display("Mismatch out_data[%0d] serial: got %h expected %h",
							i, out_data[i][15:0], m_serial[i]);
						errors++;
					end
					m_serial[i] = m_serial[i] + 16'd1;
					m_open = 1'b1;
				end
				if (eop_lanes[i]) begin
					assert (m_open) else begin
						$display("Mismatch out_eop lane %0d: end while closed, eop %h",
							i, out_eop);
						errors++;
					end
					assert (out_data[i] == TRAILER) else begin
						$display("Mismatch out_data[%0d] trailer: got %h expected %h",
							i, out_data[i], TRAILER);
						errors++;
					end
					if (m_open)
						m_packets++;
					m_open = 1'b0;
				end
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// concurrent checks on the observed stream

	// a shared lane would make a one word packet
	a_lane_exclusive: assert property (@(posedge clk) disable iff (reset)
		out_valid |-> (out_sop & eop_lanes) == '0)
		else begin
			$display("sop and eop were seen in the same lane");
			errors++;
		end

	a_stall_stable: assert property (@(posedge clk) disable iff (reset)
		out_valid && !out_ready |=> out_valid && $stable(out_sop) &&
			$stable(out_eop) && $stable(out_data))
		else begin
			$display("a stalled beat changed before it was accepted");
			errors++;
		end

	// the sink stalls exactly while hold is high
	a_ready_from_hold: assert property (@(posedge clk)
		out_ready == !hold)
		else begin
			$display("Mismatch out_ready: got %h expected %h", out_ready, !hold);
			errors++;
		end

	a_checker_clean: assert property (@(posedge clk) disable iff (reset)
		counts.framing_err == 0 && counts.dest_err == 0 &&
		counts.serial_err == 0 && counts.trailer_err == 0)
		else begin
			$display("the checker counted an error");
			errors++;
		end

	// after the drain nothing new may start
	a_drain_quiet: assert property (@(posedge clk) disable iff (reset)
		quiet |-> !(out_valid && |out_sop) && !open_pkt)
		else begin
			$display("a packet started or stayed open after the idle drain");
			errors++;
		end

	////////////////////////////////////////////////////////////////////////////
	// stimulus helpers

	task automatic step();
		@(posedge clk);
		#1;
	endtask

	task automatic wait_packets(input int target, input int limit, input bit shake,
		output bit done);
		int cycles;
		cycles = 0;
		while (m_packets < target && cycles < limit) begin
			step();
			// roughly four cycles in ten stalled
			if (shake)
				hold = ($urandom % 10) < 4;
			cycles++;
		end
		hold = 1'b0;
		done = m_packets >= target;
	endtask

	task automatic drain_idle(output bit done);
		int cycles;
		int streak;
		cycles = 0;
		streak = 0;
		idle = 1'b1;
		hold = 1'b0;
		// open_pkt has to settle low within the 64 cycle bound
		while (streak < 8 && cycles < 64) begin
			step();
			cycles++;
			streak = open_pkt ? 0 : streak + 1;
		end
		done = streak >= 8;
	endtask

	////////////////////////////////////////////////////////////////////////////
	// main sequence

	initial begin
		reset = 1'b1;
		run = 1'b0;
		idle = 1'b0;
		hold = 1'b0;
		quiet = 1'b0;
		errors = 0;
		ok = 1'b1;
		void'($urandom(32'hf054_79d7));
		repeat (10) @(posedge clk);
		#1;
		reset = 1'b0;
		run = 1'b1;

		wait_packets(20, 2000, 1'b0, ok);
		if (!ok)
			$display("free run: timed out waiting for packets");
		else
			$display("free run: %0d packets, errors %0d", m_packets, errors);

		if (ok) begin
			wait_packets(m_packets + 20, 4000, 1'b1, ok);
			if (!ok)
				$display("random hold: timed out waiting for packets");
			else if (stalls == 0) begin
				$display("random hold: no stalled beat was seen");
				errors++;
			end else
				$display("random hold: %0d stall cycles, errors %0d", stalls, errors);
		end

		if (ok) begin
			drain_idle(ok);
			if (!ok)
				$display("idle drain: open_pkt did not settle low within 64 cycles");
			else begin
				quiet = 1'b1;
				repeat (32) step();
				quiet = 1'b0;
				assert (counts.packets == 16'(m_packets)) else begin
					$display("Mismatch counts.packets: got %h expected %h",
						counts.packets, 16'(m_packets));
					errors++;
				end
				$display("idle drain: %0d packets, errors %0d", m_packets, errors);
			end
		end

		if (ok) begin
			idle = 1'b0;
			// serial continuity is checked by the model on every start
			wait_packets(m_packets + 10, 3000, 1'b0, ok);
			if (!ok)
				$display("restart: timed out waiting for packets");
			else
				$display("restart: %0d packets, errors %0d", m_packets, errors);
		end

		$display("packets %0d, checker packets %0d, stalls %0d, errors %0d",
			m_packets, counts.packets, stalls, errors);
		if (ok && errors == 0)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	end

endmodule

//--- filelist.f
+incdir+verilog
verilog/pkt_pkg.sv
verilog/pkt_stream_if.sv
verilog/prbs_source.sv
verilog/packet_gen.sv
verilog/packet_check.sv
verilog/pkt_loop_top.sv
bench/tb_pkt_loop.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f filelist.f --top-module tb_pkt_loop -Mdir obj_dir

./obj_dir/Vtb_pkt_loop > sim.log 2>&1 || true
cat sim.log

if grep -q "^Test passed$" sim.log; then
	exit 0
fi
exit 1
